// ==== rtl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
	input rv32i_types::rv32i_word instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output rv32i_types::rv32i_word imm,
	output rv32i_types::alu_ops aluop,
	output rv32i_types::branch_funct3_t cmpop,
	output rv32i_types::alumux1_sel_t alumux1_sel,
	output rv32i_types::alumux2_sel_t alumux2_sel,
	output rv32i_types::wbmux_sel_t wbmux_sel,
	output logic load_regfile, mem_read, mem_write,
	output logic is_branch, is_jal, is_jalr,
	output logic uses_rs1, uses_rs2
);
	import rv32i_types::*;

	rv32i_opcode opcode;
	logic [2:0] funct3;
	rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm;

	assign opcode = rv32i_opcode'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	// sign extended immediates, one per format
	assign i_imm = {{21{instr[31]}}, instr[30:20]};
	assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'h000};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = i_imm;
		aluop = alu_add;
		cmpop = branch_funct3_t'(funct3);
		alumux1_sel = mux1_rs1;
		alumux2_sel = mux2_imm;
		wbmux_sel = wb_alu;
		load_regfile = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		is_jalr = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			op_lui: begin
				imm = u_imm;
				aluop = alu_pass_b;
				load_regfile = 1'b1;
			end
			op_auipc: begin
				imm = u_imm;
				alumux1_sel = mux1_pc;
				load_regfile = 1'b1;
			end
			// ALU forms the target, rd takes the link
			op_jal: begin
				imm = j_imm;
				alumux1_sel = mux1_pc;
				wbmux_sel = wb_pc_plus4;
				load_regfile = 1'b1;
				is_jal = 1'b1;
			end
			op_jalr: begin
				wbmux_sel = wb_pc_plus4;
				load_regfile = 1'b1;
				is_jalr = 1'b1;
				uses_rs1 = 1'b1;
			end
			op_br: begin
				imm = b_imm;
				alumux1_sel = mux1_pc;
				is_branch = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			op_load: begin
				wbmux_sel = wb_load;
				load_regfile = 1'b1;
				mem_read = 1'b1;
				uses_rs1 = 1'b1;
			end
			op_store: begin
				imm = s_imm;
				mem_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			op_imm, op_reg: begin
				load_regfile = 1'b1;
				uses_rs1 = 1'b1;
				if (opcode == op_reg) begin
					alumux2_sel = mux2_rs2;
					uses_rs2 = 1'b1;
				end
				case (funct3)
					3'b000: aluop = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
					3'b001: aluop = alu_sll;
					// set-less-than goes through the comparator
					3'b010: begin
						aluop = alu_slt;
						cmpop = blt;
						wbmux_sel = wb_br_en;
					end
					3'b011: begin
						aluop = alu_sltu;
						cmpop = bltu;
						wbmux_sel = wb_br_en;
					end
					3'b100: aluop = alu_xor;
					3'b101: aluop = instr[30] ? alu_sra : alu_srl;
					3'b110: aluop = alu_or;
					default: aluop = alu_and;
				endcase
			end
			default: begin
				// unknown opcode, nothing enabled
			end
		endcase
	end

endmodule

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath #(
	parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input logic resp_b,
	input rv32i_types::rv32i_word rdata_a,
	input rv32i_types::rv32i_word rdata_b,
	output logic read_a,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output rv32i_types::rv32i_word address_a,
	output rv32i_types::rv32i_word address_b,
	output rv32i_types::rv32i_word wdata
);
	import rv32i_types::*;

	// fetch
	rv32i_word pc, if_buf, fetch_word;
	logic if_done, fetch_ok;
	// IF/ID
	logic ifid_valid;
	rv32i_word ifid_instr, ifid_pc;
	// decode
	logic [4:0] id_rs1, id_rs2, id_rd;
	rv32i_word id_imm, id_rs1_val, id_rs2_val;
	alu_ops id_aluop;
	branch_funct3_t id_cmpop;
	alumux1_sel_t id_mux1;
	alumux2_sel_t id_mux2;
	wbmux_sel_t id_wbmux;
	logic id_load_regfile, id_mem_read, id_mem_write;
	logic id_is_branch, id_is_jal, id_is_jalr, id_uses_rs1, id_uses_rs2;
	// ID/EX
	logic idex_valid;
	rv32i_word idex_pc, idex_imm, idex_rs1_val, idex_rs2_val;
	logic [4:0] idex_rd;
	alu_ops idex_aluop;
	branch_funct3_t idex_cmpop;
	alumux1_sel_t idex_mux1;
	alumux2_sel_t idex_mux2;
	wbmux_sel_t idex_wbmux;
	logic idex_load_regfile, idex_mem_read, idex_mem_write;
	logic idex_is_branch, idex_is_jal, idex_is_jalr;
	// execute
	rv32i_word alu_a, alu_b, cmp_b, alu_out, target;
	logic br_en, take;
	// EX/MEM
	logic exmem_valid, exmem_br_en;
	rv32i_word exmem_alu, exmem_pc4, exmem_rs2_val;
	logic [4:0] exmem_rd;
	wbmux_sel_t exmem_wbmux;
	logic exmem_load_regfile, exmem_mem_read, exmem_mem_write;
	// memory
	logic mem_done, mem_ok;
	rv32i_word mem_buf, mem_word;
	// MEM/WB
	logic memwb_valid, memwb_br_en, memwb_load_regfile;
	rv32i_word memwb_alu, memwb_pc4, memwb_rdata, wb_value;
	logic [4:0] memwb_rd;
	wbmux_sel_t memwb_wbmux;
	// hazards
	logic advance, hazard_rs1, hazard_rs2, interlock, pc_load;

	// fetch port, request held until the word is latched
	assign read_a = !if_done;
	assign address_a = pc;
	assign fetch_ok = if_done || resp_a;
	assign fetch_word = if_done ? if_buf : rdata_a;

	cpu_control control (
		.instr(ifid_instr),
		.rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
		.imm(id_imm),
		.aluop(id_aluop),
		.cmpop(id_cmpop),
		.alumux1_sel(id_mux1),
		.alumux2_sel(id_mux2),
		.wbmux_sel(id_wbmux),
		.load_regfile(id_load_regfile),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.is_branch(id_is_branch),
		.is_jal(id_is_jal),
		.is_jalr(id_is_jalr),
		.uses_rs1(id_uses_rs1),
		.uses_rs2(id_uses_rs2)
	);

	regfile regs (
		.clk,
		.rst_n,
		.load(memwb_valid && memwb_load_regfile),
		.dest(memwb_rd),
		.in(wb_value),
		.src_a(id_rs1),
		.src_b(id_rs2),
		.reg_a(id_rs1_val),
		.reg_b(id_rs2_val)
	);

	// RAW against EX and MEM; WB is covered by the regfile
	assign hazard_rs1 = id_uses_rs1 && (id_rs1 != 5'd0) &&
		((idex_valid && idex_load_regfile && idex_rd == id_rs1) ||
		(exmem_valid && exmem_load_regfile && exmem_rd == id_rs1));
	assign hazard_rs2 = id_uses_rs2 && (id_rs2 != 5'd0) &&
		((idex_valid && idex_load_regfile && idex_rd == id_rs2) ||
		(exmem_valid && exmem_load_regfile && exmem_rd == id_rs2));
	assign interlock = ifid_valid && (hazard_rs1 || hazard_rs2);

	assign alu_a = (idex_mux1 == mux1_pc) ? idex_pc : idex_rs1_val;
	assign alu_b = (idex_mux2 == mux2_rs2) ? idex_rs2_val : idex_imm;
	// branches compare rs2 while the ALU builds pc + imm
	assign cmp_b = idex_is_branch ? idex_rs2_val : alu_b;

	exec_unit exec (
		.aluop(idex_aluop),
		.cmpop(idex_cmpop),
		.a(alu_a),
		.b(alu_b),
		.cmp_b(cmp_b),
		.alu_out(alu_out),
		.br_en(br_en)
	);

	assign take = idex_valid && (idex_is_jal || idex_is_jalr || (idex_is_branch && br_en));
	assign target = {alu_out[31:1], alu_out[0] & ~idex_is_jalr};

	// data port, driven straight from EX/MEM
	assign read_b = exmem_valid && exmem_mem_read && !mem_done;
	assign write = exmem_valid && exmem_mem_write && !mem_done;
	assign wmask = 4'b1111;
	assign address_b = exmem_alu;
	assign wdata = exmem_rs2_val;
	assign mem_ok = !(exmem_valid && (exmem_mem_read || exmem_mem_write)) || mem_done || resp_b;
	assign mem_word = mem_done ? mem_buf : rdata_b;

	// whole pipe steps only when both ports are satisfied
	assign advance = fetch_ok && mem_ok;
	assign pc_load = advance && (take || !interlock);

	always_comb begin
		case (memwb_wbmux)
			wb_alu: wb_value = memwb_alu;
			wb_br_en: wb_value = {31'd0, memwb_br_en};
			wb_pc_plus4: wb_value = memwb_pc4;
			default: wb_value = memwb_rdata;
		endcase
	end

	// early responses are parked so the ports can finish in either order
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_done <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			if (pc_load) begin
				if_done <= 1'b0;
			end else if (resp_a) begin
				if_done <= 1'b1;
			end
			if (advance) begin
				mem_done <= 1'b0;
			end else if (resp_b) begin
				mem_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp_a) begin
			if_buf <= rdata_a;
		end
		if (resp_b) begin
			mem_buf <= rdata_b;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			ifid_valid <= 1'b0;
			idex_valid <= 1'b0;
			exmem_valid <= 1'b0;
			memwb_valid <= 1'b0;
		end else if (advance) begin
			memwb_valid <= exmem_valid;
			exmem_valid <= idex_valid;
			if (take) begin
				// squash the two younger stages
				pc <= target;
				ifid_valid <= 1'b0;
				idex_valid <= 1'b0;
			end else if (interlock) begin
				idex_valid <= 1'b0;
			end else begin
				pc <= pc + 32'd4;
				ifid_valid <= 1'b1;
				idex_valid <= ifid_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if (!take && !interlock) begin
				ifid_instr <= fetch_word;
				ifid_pc <= pc;
			end
			idex_pc <= ifid_pc;
			idex_imm <= id_imm;
			idex_rs1_val <= id_rs1_val;
			idex_rs2_val <= id_rs2_val;
			idex_rd <= id_rd;
			idex_aluop <= id_aluop;
			idex_cmpop <= id_cmpop;
			idex_mux1 <= id_mux1;
			idex_mux2 <= id_mux2;
			idex_wbmux <= id_wbmux;
			idex_load_regfile <= id_load_regfile;
			idex_mem_read <= id_mem_read;
			idex_mem_write <= id_mem_write;
			idex_is_branch <= id_is_branch;
			idex_is_jal <= id_is_jal;
			idex_is_jalr <= id_is_jalr;
			exmem_alu <= alu_out;
			exmem_br_en <= br_en;
			exmem_pc4 <= idex_pc + 32'd4;
			exmem_rs2_val <= idex_rs2_val;
			exmem_rd <= idex_rd;
			exmem_wbmux <= idex_wbmux;
			exmem_load_regfile <= idex_load_regfile;
			exmem_mem_read <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
			memwb_alu <= exmem_alu;
			memwb_br_en <= exmem_br_en;
			memwb_pc4 <= exmem_pc4;
			memwb_rdata <= mem_word;
			memwb_rd <= exmem_rd;
			memwb_wbmux <= exmem_wbmux;
			memwb_load_regfile <= exmem_load_regfile;
		end
	end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	input logic mem_resp,
	input rv32i_types::rv32i_word mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output logic [3:0] mem_wmask,
	output rv32i_types::rv32i_word mem_address,
	output rv32i_types::rv32i_word mem_wdata
);
	import rv32i_types::*;

	// fetch and data ports between core and arbiter
	logic read_a, read_b, write, resp_a, resp_b;
	logic [3:0] wmask;
	rv32i_word address_a, address_b, wdata, rdata_a, rdata_b;

	cpu_datapath #(
		.RESET_PC(RESET_PC)
	) datapath (
		.clk,
		.rst_n,
		.resp_a,
		.resp_b,
		.rdata_a,
		.rdata_b,
		.read_a,
		.read_b,
		.write,
		.wmask,
		.address_a,
		.address_b,
		.wdata
	);

	mem_arbiter arbiter (
		.clk,
		.rst_n,
		.read_a,
		.address_a,
		.read_b,
		.write,
		.wmask,
		.address_b,
		.wdata,
		.mem_resp,
		.mem_rdata,
		.resp_a,
		.resp_b,
		.rdata_a,
		.rdata_b,
		.mem_read,
		.mem_write,
		.mem_wmask,
		.mem_address,
		.mem_wdata
	);

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
	input rv32i_types::alu_ops aluop,
	input rv32i_types::branch_funct3_t cmpop,
	input rv32i_types::rv32i_word a,
	input rv32i_types::rv32i_word b,
	input rv32i_types::rv32i_word cmp_b,
	output rv32i_types::rv32i_word alu_out,
	output logic br_en
);
	import rv32i_types::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (aluop)
			alu_add: alu_out = a + b;
			alu_sub: alu_out = a - b;
			alu_sll: alu_out = a << shamt;
			alu_slt: alu_out = {31'd0, $signed(a) < $signed(b)};
			alu_sltu: alu_out = {31'd0, a < b};
			alu_xor: alu_out = a ^ b;
			alu_srl: alu_out = a >> shamt;
			alu_sra: alu_out = rv32i_word'($signed(a) >>> shamt);
			alu_or: alu_out = a | b;
			alu_and: alu_out = a & b;
			alu_pass_b: alu_out = b;
			default: alu_out = '0;
		endcase
	end

	// comparator, also serves slt/sltu writeback
	always_comb begin
		case (cmpop)
			beq: br_en = (a == cmp_b);
			bne: br_en = (a != cmp_b);
			blt: br_en = ($signed(a) < $signed(cmp_b));
			bge: br_en = ($signed(a) >= $signed(cmp_b));
			bltu: br_en = (a < cmp_b);
			bgeu: br_en = (a >= cmp_b);
			default: br_en = 1'b0;
		endcase
	end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
	input logic clk,
	input logic rst_n,
	input logic read_a,
	input rv32i_types::rv32i_word address_a,
	input logic read_b,
	input logic write,
	input logic [3:0] wmask,
	input rv32i_types::rv32i_word address_b,
	input rv32i_types::rv32i_word wdata,
	input logic mem_resp,
	input rv32i_types::rv32i_word mem_rdata,
	output logic resp_a,
	output logic resp_b,
	output rv32i_types::rv32i_word rdata_a,
	output rv32i_types::rv32i_word rdata_b,
	output logic mem_read,
	output logic mem_write,
	output logic [3:0] mem_wmask,
	output rv32i_types::rv32i_word mem_address,
	output rv32i_types::rv32i_word mem_wdata
);
	import rv32i_types::*;

	typedef enum logic [1:0] {idle, serve_a, serve_b} arb_state_t;

	arb_state_t state;
	logic req_b;

	assign req_b = read_b || write;

	// data port wins, one transfer at a time
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (req_b) begin
						state <= serve_b;
						mem_read <= read_b;
						mem_write <= write;
					end else if (read_a) begin
						state <= serve_a;
						mem_read <= 1'b1;
						mem_write <= 1'b0;
					end
				end
				serve_a, serve_b: begin
					if (mem_resp) begin
						state <= idle;
						mem_read <= 1'b0;
						mem_write <= 1'b0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// address and data captured with the grant
	always_ff @(posedge clk) begin
		if (state == idle) begin
			mem_address <= req_b ? address_b : address_a;
			mem_wdata <= wdata;
			mem_wmask <= write ? wmask : 4'b0000;
		end
	end

	assign resp_a = (state == serve_a) && mem_resp;
	assign resp_b = (state == serve_b) && mem_resp;
	assign rdata_a = (state == serve_a) ? mem_rdata : '0;
	assign rdata_b = (state == serve_b) ? mem_rdata : '0;

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic [4:0] dest,
	input rv32i_types::rv32i_word in,
	input logic [4:0] src_a,
	input logic [4:0] src_b,
	output rv32i_types::rv32i_word reg_a,
	output rv32i_types::rv32i_word reg_b
);
	import rv32i_types::*;

	rv32i_word regs [32];
	logic wr_en;

	assign wr_en = load && (dest != 5'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[dest] <= in;
		end
	end

	// write-through so a WB producer is seen by ID in the same cycle
	assign reg_a = (src_a == 5'd0) ? '0 : (wr_en && dest == src_a) ? in : regs[src_a];
	assign reg_b = (src_b == 5'd0) ? '0 : (wr_en && dest == src_b) ? in : regs[src_b];

endmodule

// ==== rtl/rv32i_types.sv ====
package rv32i_types;

	typedef logic [31:0] rv32i_word;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_ops;

	// encoded exactly as the branch funct3 field
	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic {mux1_rs1, mux1_pc} alumux1_sel_t;

	typedef enum logic {mux2_imm, mux2_rs2} alumux2_sel_t;

	typedef enum logic [1:0] {wb_alu, wb_br_en, wb_pc_plus4, wb_load} wbmux_sel_t;

endpackage

// ==== tb.f ====
rtl/rv32i_types.sv
rtl/cpu_control.sv
rtl/regfile.sv
rtl/exec_unit.sv
rtl/cpu_datapath.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
tests/mem_model.sv
tests/cpu_top_tb.sv

// ==== tests/cpu_top_tb.sv ====
`timescale 1ns/1ps

module cpu_top_tb;
	import rv32i_types::*;

	logic clk;
	logic rst_n;
	logic mem_resp, mem_read, mem_write;
	logic [3:0] mem_wmask;
	rv32i_word mem_rdata, mem_address, mem_wdata;

	rv32i_word exp_addr [$];
	rv32i_word exp_data [$];
	string test_names [3] = '{"alu_ops", "lui_auipc_mem", "branch_jump"};
	int test_last [3] = '{2, 4, 7};
	int store_idx = 0;
	int cur_test = 0;
	int test_bad = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	int limit;

	cpu_top #(.RESET_PC(32'h0000_0000)) cpu_top_inst (
		.clk, .rst_n, .mem_resp, .mem_rdata,
		.mem_read, .mem_write, .mem_wmask, .mem_address, .mem_wdata
	);

	mem_model memory (
		.clk, .rst_n, .mem_read, .mem_write, .mem_wmask,
		.mem_address, .mem_wdata, .mem_resp, .mem_rdata
	);

	always #50 clk = ~clk;

	// sequential ISA model, returns executed instruction count
	function automatic int ref_run();
		rv32i_word mem [1024];
		rv32i_word x [32];
		rv32i_word pc, ins, a, b, op2, res, next, imm_i, imm_s, imm_b, imm_j;
		rv32i_opcode op;
		logic [2:0] f3;
		logic wr, cond;
		int count;
		$readmemh("tests/program.hex", mem);
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		pc = '0;
		count = 0;
		while (count < 10000) begin
			ins = mem[pc[11:2]];
			count++;
			op = rv32i_opcode'(ins[6:0]);
			f3 = ins[14:12];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			next = pc + 4;
			wr = 1'b0;
			res = '0;
			case (op)
				op_lui: begin
					res = {ins[31:12], 12'h000};
					wr = 1'b1;
				end
				op_auipc: begin
					res = pc + {ins[31:12], 12'h000};
					wr = 1'b1;
				end
				op_jal: begin
					res = pc + 4;
					wr = 1'b1;
					next = pc + imm_j;
				end
				op_jalr: begin
					res = pc + 4;
					wr = 1'b1;
					next = (a + imm_i) & ~32'd1;
				end
				op_br: begin
					case (f3)
						3'b000: cond = (a == b);
						3'b001: cond = (a != b);
						3'b100: cond = ($signed(a) < $signed(b));
						3'b101: cond = ($signed(a) >= $signed(b));
						3'b110: cond = (a < b);
						default: cond = (a >= b);
					endcase
					if (cond) begin
						next = pc + imm_b;
					end
				end
				op_load: begin
					res = mem[(a + imm_i) >> 2];
					wr = 1'b1;
				end
				op_store: begin
					mem[(a + imm_s) >> 2] = b;
					exp_addr.push_back(a + imm_s);
					exp_data.push_back(b);
				end
				op_imm, op_reg: begin
					op2 = (op == op_reg) ? b : imm_i;
					case (f3)
						3'b000: res = (op == op_reg && ins[30]) ? a - op2 : a + op2;
						3'b001: res = a << op2[4:0];
						3'b010: res = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
						3'b011: res = (a < op2) ? 32'd1 : 32'd0;
						3'b100: res = a ^ op2;
						3'b101: begin
							// arithmetic shift keeps the sign bit
							if (ins[30]) begin
								res = $signed(a) >>> op2[4:0];
							end else begin
								res = a >> op2[4:0];
							end
						end
						3'b110: res = a | op2;
						default: res = a & op2;
					endcase
					wr = 1'b1;
				end
				default: begin
				end
			endcase
			if (wr && ins[11:7] != 5'd0) begin
				x[ins[11:7]] = res;
			end
			// closing self-loop
			if (next == pc) begin
				break;
			end
			pc = next;
		end
		return count;
	endfunction

	task automatic check_addr(input string name, input rv32i_word exp, input rv32i_word act);
		if (exp !== act) begin
			$display("FAIL %s address expected %h actual %h", name, exp, act);
			test_bad = 1;
		end
	endtask

	task automatic check_data(input string name, input rv32i_word exp, input rv32i_word act);
		if (exp !== act) begin
			$display("FAIL %s data expected %h actual %h", name, exp, act);
			test_bad = 1;
		end
	endtask

	task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (exp !== act) begin
			$display("FAIL %s mask expected %b actual %b", name, exp, act);
			test_bad = 1;
		end
	endtask

	// a store completes on the edge where the bus sees mem_resp
	always @(posedge clk) begin
		// each response ends exactly one read or one write
		if (rst_n && mem_resp && mem_read === mem_write) begin
			$display("bus response with read %b and write %b, not exactly one request",
				mem_read, mem_write);
			fail_cnt++;
		end
		if (rst_n && mem_write && mem_resp) begin
			if (store_idx >= exp_addr.size()) begin
				$display("unexpected extra store to %h with data %h", mem_address, mem_wdata);
				fail_cnt++;
			end else begin
				check_addr(test_names[cur_test], exp_addr[store_idx], mem_address);
				check_data(test_names[cur_test], exp_data[store_idx], mem_wdata);
				check_mask(test_names[cur_test], 4'b1111, mem_wmask);
				if (store_idx == test_last[cur_test]) begin
					if (test_bad == 0) begin
						$display("PASS %s", test_names[cur_test]);
						pass_cnt++;
					end else begin
						fail_cnt++;
					end
					test_bad = 0;
					if (cur_test < 2) begin
						cur_test++;
					end
				end
			end
			store_idx++;
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (cycles >= limit) begin
				$display("timeout: test %s never finished, %0d of %0d stores seen",
					test_names[cur_test], store_idx, exp_addr.size());
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	initial begin
		void'($urandom(13));
		clk = 1'b0;
		rst_n = 1'b0;
		limit = ref_run() * 5 * 6;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		wait (store_idx >= exp_addr.size());
		// let any stray store show up
		repeat (20) @(posedge clk);
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (pass_cnt == 3 && fail_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic [3:0] mem_wmask,
	input rv32i_types::rv32i_word mem_address,
	input rv32i_types::rv32i_word mem_wdata,
	output logic mem_resp,
	output rv32i_types::rv32i_word mem_rdata
);
	import rv32i_types::*;

	rv32i_word mem [1024];
	logic busy;
	int wait_cnt;

	initial begin
		$readmemh("tests/program.hex", mem);
	end

	// one transfer at a time, answered after 1 to 4 cycles
	always @(posedge clk) begin
		if (!rst_n) begin
			mem_resp <= 1'b0;
			mem_rdata <= '0;
			busy <= 1'b0;
			wait_cnt <= 0;
		end else begin
			mem_resp <= 1'b0;
			if (mem_resp) begin
				busy <= 1'b0;
			end else if (!busy && (mem_read || mem_write)) begin
				busy <= 1'b1;
				wait_cnt <= $urandom_range(3, 0);
			end else if (busy) begin
				if (wait_cnt == 0) begin
					mem_resp <= 1'b1;
					mem_rdata <= mem[mem_address[11:2]];
					if (mem_write) begin
						for (int i = 0; i < 4; i++) begin
							if (mem_wmask[i]) begin
								mem[mem_address[11:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
							end
						end
					end
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
		end
	end

endmodule

// ==== tests/program.hex ====
// one 32-bit instruction word per line, hex, loaded from address 0
// stores go to a data region at 0x200 addressed through x10
00500093
FFD00113
20000513
402081B3
00309233
001122B3
40115393
00724433
00352023
00552223
00852423
123455B7
00001617
00B52623
00C52683
00C68733
00E52823
00208463
00178793
00209463
00178793
00114463
00178793
00115463
00178793
00116463
00178793
00117463
00178793
0080086F
00178793
00C808E7
00178793
00F52A23
01052C23
01152E23
0000006F
